// ==== sources.f ====
+incdir+.
bru_pkg.sv
bru_issue_entry.sv
bru_issue_queue.sv
bru_regfile.sv
bru_exec.sv
bru_sched_top.sv
bru_sched_sva.sv
tb_bru_sched.sv

// ==== Bender.yml ====
package:
  name: bru_sched

export_include_dirs:
  - .

sources:
  - bru_pkg.sv
  - bru_issue_entry.sv
  - bru_issue_queue.sv
  - bru_regfile.sv
  - bru_exec.sv
  - bru_sched_top.sv
  - target: test
    files:
      - bru_sched_sva.sv
      - tb_bru_sched.sv

// ==== tb_bru_sched.sv ====
`timescale 1ns/1ps
`include "bru_consts.svh"

module tb_bru_sched
  import bru_pkg::*;
;
  localparam int TOTAL_OPS = 225;
  localparam int CYCLE_LIMIT = 40 * TOTAL_OPS + 200;

  logic i_clk, i_reset_n, i_disp_valid, i_disp_rs1_ready, i_disp_rs2_ready, i_disp_pred_taken;
  logic [`AGE_W-1:0] i_disp_cmt_id;
  br_op_t i_disp_op;
  logic [`PREG_W-1:0] i_disp_rs1, i_disp_rs2, i_wb_preg, i_early_preg, i_cancel_preg;
  logic [`XLEN-1:0] i_wb_data;
  logic i_wb_valid, i_early_valid, i_cancel_valid, i_res_ready;
  logic o_disp_ready, o_res_valid, o_res_taken, o_res_mispred;
  logic [`AGE_W-1:0] o_res_cmt_id;

  logic [`XLEN-1:0] model_regs [1 << `PREG_W];  // Reference register array
  logic pending [1 << `AGE_W];
  br_op_t m_op [1 << `AGE_W];
  logic [`PREG_W-1:0] m_rs1 [1 << `AGE_W];
  logic [`PREG_W-1:0] m_rs2 [1 << `AGE_W];
  logic m_pred [1 << `AGE_W];
  logic held_prev, order_check, rand_ready;
  logic [31:0] lcg_state;
  logic [`AGE_W-1:0] next_id;
  int n_pend, n_res, n_err, cycles, base;

  bru_sched_top UUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  function logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Id a is ahead of id b within half the id space
  function automatic logic id_younger(input logic [`AGE_W-1:0] a, input logic [`AGE_W-1:0] b);
    logic [`AGE_W-1:0] d;
    d = a - b;
    return (d != 0) && (d < (1 << (`AGE_W - 1)));
  endfunction

  // Returns {taken, mispredict}
  function automatic logic [1:0] ref_branch(input br_op_t op, input logic [31:0] a,
                                            input logic [31:0] b, input logic pred);
    logic t;
    case (op)
      BEQ:     t = (a == b);
      BNE:     t = (a != b);
      BLT:     t = ($signed(a) < $signed(b));
      BGE:     t = ($signed(a) >= $signed(b));
      BLTU:    t = (a < b);
      default: t = (a >= b);
    endcase
    return {t, t ^ pred};
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %0t ns: %s got %0h expected %0h", $time, what, got, exp);
      n_err++;
    end
  endtask

  // ---------------------------------------
  // Result monitor and compare
  // ---------------------------------------
  always @(posedge i_clk) begin
    logic [1:0] exp;
    logic [`AGE_W-1:0] id;
    if (i_reset_n) begin
      id = o_res_cmt_id;
      if (i_disp_valid && o_disp_ready) begin
        m_op[i_disp_cmt_id] = i_disp_op;
        m_rs1[i_disp_cmt_id] = i_disp_rs1;
        m_rs2[i_disp_cmt_id] = i_disp_rs2;
        m_pred[i_disp_cmt_id] = i_disp_pred_taken;
        pending[i_disp_cmt_id] = 1'b1;
        n_pend++;
      end
      if (o_res_valid && !held_prev && pending[id]) begin
        exp = ref_branch(m_op[id], model_regs[m_rs1[id]], model_regs[m_rs2[id]], m_pred[id]);
        for (int j = 0; j < (1 << `AGE_W); j++) begin
          if (exp[0] && pending[j] && id_younger(j, id)) begin
            pending[j] = 1'b0;  // Flushed by this mispredict
            n_pend--;
          end
        end
      end
      if (o_res_valid && i_res_ready) begin
        if (!pending[id]) begin
          $display("Unexpected or duplicate result for id %0d at %0t ns", id, $time);
          n_err++;
        end else begin
          exp = ref_branch(m_op[id], model_regs[m_rs1[id]], model_regs[m_rs2[id]], m_pred[id]);
          check("taken", o_res_taken, exp[1]);
          check("mispredict", o_res_mispred, exp[0]);
          for (int j = 0; j < (1 << `AGE_W); j++) begin
            if (order_check && pending[j] && id_younger(id, j)) begin
              $display("Result for id %0d came before older id %0d at %0t ns", id, j, $time);
              n_err++;
            end
          end
          pending[id] = 1'b0;
          n_pend--;
          n_res++;
        end
      end
      held_prev = o_res_valid && !i_res_ready;
      if (i_wb_valid) model_regs[i_wb_preg] = i_wb_data;
    end
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge i_clk);
      cycles++;
    end
    $display("Timeout: the DUT stopped producing results after %0d cycles", cycles);
    $display("Test FAILED");
    $finish;
  end

  // ---------------------------------------
  // Stimulus tasks, all on the falling edge
  // ---------------------------------------
  task automatic step();
    @(negedge i_clk);
    i_disp_valid = 1'b0;
    i_wb_valid = 1'b0;
    i_early_valid = 1'b0;
    i_cancel_valid = 1'b0;
    if (rand_ready) i_res_ready = lcg_next() >> 16;
  endtask

  task automatic dispatch(input br_op_t op, input int rs1, input int rs2, input logic r1,
                          input logic r2, input logic pred);
    step();
    while (!o_disp_ready) step();
    {i_disp_op, i_disp_rs1, i_disp_rs2} = {op, rs1[`PREG_W-1:0], rs2[`PREG_W-1:0]};
    {i_disp_rs1_ready, i_disp_rs2_ready, i_disp_pred_taken} = {r1, r2, pred};
    i_disp_cmt_id = next_id;
    i_disp_valid = 1'b1;
    next_id++;
  endtask

  task automatic write_reg(input int preg, input logic [31:0] data);
    step();
    i_wb_valid = 1'b1;
    i_wb_preg = preg[`PREG_W-1:0];
    i_wb_data = data;
  endtask

  // Wait until every recorded branch has resolved or been flushed
  task automatic wait_idle();
    step();
    while (n_pend != 0) step();
    repeat (4) step();
  endtask

  task automatic drain(input string name);
    wait_idle();
    $display("%s done, results %0d, errors %0d", name, n_res, n_err);
  endtask

  // Correct prediction from the model's current register values
  function automatic logic good_pred(input br_op_t op, input int rs1, input int rs2);
    logic [1:0] r;
    r = ref_branch(op, model_regs[rs1], model_regs[rs2], 1'b0);
    return r[1];
  endfunction

  initial begin
    br_op_t op;
    {i_reset_n, i_disp_valid, i_wb_valid, i_early_valid, i_cancel_valid} = '0;
    {i_disp_rs1_ready, i_disp_rs2_ready, i_disp_pred_taken, i_res_ready} = 4'b0001;
    {i_disp_cmt_id, i_disp_rs1, i_disp_rs2, i_wb_preg, i_early_preg, i_cancel_preg} = '0;
    i_disp_op = BEQ;
    i_wb_data = '0;
    {held_prev, order_check, rand_ready, n_pend, n_res, n_err, next_id} = '0;
    lcg_state = 32'h76ea;
    for (int i = 0; i < (1 << `PREG_W); i++) model_regs[i] = '0;
    for (int i = 0; i < (1 << `AGE_W); i++) pending[i] = 1'b0;
    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;
    check("dispatch ready after reset", o_disp_ready, 1);
    check("result valid after reset", o_res_valid, 0);

    // Signed and unsigned edge values
    write_reg(1, 32'h8000_0000);
    write_reg(2, 32'h7fff_ffff);
    write_reg(4, 32'd1);
    write_reg(5, 32'd1);
    for (int k = 0; k < 6; k++) begin
      dispatch(br_op_t'(k), 1, 2, 1'b1, 1'b1, lcg_next() >> 20);
      wait_idle();
      dispatch(br_op_t'(k), 4, 5, 1'b1, 1'b1, lcg_next() >> 20);
      wait_idle();
    end
    $display("six branch types done, errors %0d", n_err);

    base = n_res;
    dispatch(BNE, 6, 4, 1'b0, 1'b1, 1'b0);
    dispatch(BGEU, 7, 8, 1'b0, 1'b0, 1'b0);
    repeat (8) step();
    check("results before writeback", n_res - base, 0);
    write_reg(6, 32'd1);
    write_reg(7, 32'd3);
    write_reg(8, 32'd9);
    drain("wakeup by writeback");

    order_check = 1'b1;
    i_res_ready = 1'b0;
    for (int k = 0; k < 4; k++) begin
      op = br_op_t'(lcg_next() % 6);
      dispatch(op, k + 1, 5 - k, 1'b1, 1'b1, good_pred(op, k + 1, 5 - k));
    end
    repeat (6) step();
    i_res_ready = 1'b1;
    drain("oldest first");
    order_check = 1'b0;

    base = n_res;
    dispatch(BLTU, 10, 4, 1'b0, 1'b1, 1'b0);
    step();
    i_early_valid = 1'b1;
    i_early_preg = 10;
    step();
    i_cancel_valid = 1'b1;  // Withdraw the promise
    i_cancel_preg = 10;
    repeat (4) step();
    write_reg(10, 32'd100);
    dispatch(BEQ, 11, 4, 1'b0, 1'b1, 1'b1);
    step();
    i_early_valid = 1'b1;
    i_early_preg = 11;
    write_reg(11, 32'd1);
    drain("speculative replay");
    check("replay result count", n_res - base, 2);

    base = n_res;
    dispatch(BEQ, 4, 5, 1'b1, 1'b1, 1'b1);
    dispatch(BNE, 4, 5, 1'b1, 1'b1, 1'b1);  // Mispredicts
    dispatch(BLT, 1, 2, 1'b1, 1'b1, 1'b1);
    dispatch(BGE, 1, 2, 1'b1, 1'b1, 1'b0);
    dispatch(BEQ, 4, 5, 1'b1, 1'b1, 1'b1);  // Lands in the flush cycle
    drain("mispredict flush");
    check("flush result count", n_res - base, 2);

    for (int k = 1; k < 9; k++) write_reg(k, (lcg_next() & 32'h1) ? lcg_next() : lcg_next() & 7);
    rand_ready = 1'b1;
    for (int k = 0; k < 200; k++) begin
      dispatch(br_op_t'(lcg_next() % 6), 1 + lcg_next() % 8, 1 + lcg_next() % 8,
               1'b1, 1'b1, lcg_next() >> 15);
    end
    rand_ready = 1'b0;
    i_res_ready = 1'b1;
    drain("random back-pressure");

    n_err += UUT.u_sva.fail_count;
    $display("Results %0d, errors %0d", n_res, n_err);
    if (n_err == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== bru_sched_sva.sv ====
`timescale 1ns/1ps
`include "bru_consts.svh"

module bru_sched_sva (
  input logic              i_clk,
  input logic              i_reset_n,
  input logic              i_disp_valid,
  input logic              o_disp_ready,
  input logic              o_res_valid,
  input logic              i_res_ready,
  input logic [`AGE_W-1:0] o_res_cmt_id,
  input logic              o_res_taken,
  input logic              o_res_mispred,
  input logic              flush_valid
);

  logic seen_disp;  // Any dispatch since reset
  logic held_q;     // Result stalled in the previous cycle
  int   fail_count = 0;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      seen_disp <= 1'b0;
      held_q    <= 1'b0;
    end else begin
      if (i_disp_valid && o_disp_ready) seen_disp <= 1'b1;
      held_q <= o_res_valid && !i_res_ready;
    end
  end

  a_res_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_res_valid && !i_res_ready |=> o_res_valid &&
      $stable({o_res_cmt_id, o_res_taken, o_res_mispred}))
    else begin
      $error("result changed while stalled");
      fail_count++;
    end

  a_no_spurious: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_res_valid |-> seen_disp)
    else begin
      $error("result without dispatch");
      fail_count++;
    end

  // Flush exactly in the first cycle of a mispredicted result
  a_flush: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    flush_valid == (o_res_valid && o_res_mispred && !held_q))
    else begin
      $error("flush not in the first cycle of a mispredicted result");
      fail_count++;
    end

endmodule

bind bru_sched_top bru_sched_sva u_sva (.*);

// ==== bru_sched_top.sv ====
`timescale 1ns/1ps
`include "bru_consts.svh"

module bru_sched_top
  import bru_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  logic               i_disp_valid,
  output logic               o_disp_ready,
  input  logic [`AGE_W-1:0]  i_disp_cmt_id,
  input  br_op_t             i_disp_op,
  input  logic [`PREG_W-1:0] i_disp_rs1,
  input  logic [`PREG_W-1:0] i_disp_rs2,
  input  logic               i_disp_rs1_ready,
  input  logic               i_disp_rs2_ready,
  input  logic               i_disp_pred_taken,
  input  logic               i_wb_valid,
  input  logic [`PREG_W-1:0] i_wb_preg,
  input  logic [`XLEN-1:0]   i_wb_data,
  input  logic               i_early_valid,
  input  logic [`PREG_W-1:0] i_early_preg,
  input  logic               i_cancel_valid,
  input  logic [`PREG_W-1:0] i_cancel_preg,
  output logic               o_res_valid,
  input  logic               i_res_ready,
  output logic [`AGE_W-1:0]  o_res_cmt_id,
  output logic               o_res_taken,
  output logic               o_res_mispred
);

  // Issue path
  logic               iss_valid;
  logic               iss_ready;
  br_op_t             iss_op;
  logic [`AGE_W-1:0]  iss_cmt_id;
  logic [`PREG_W-1:0] iss_rs1;
  logic [`PREG_W-1:0] iss_rs2;
  logic               iss_pred_taken;
  logic               replay;

  // Executor back to queue and register file
  logic               flush_valid;
  logic [`AGE_W-1:0]  flush_cmt_id;
  logic [`PREG_W-1:0] rd_rs1;
  logic [`PREG_W-1:0] rd_rs2;
  logic [`XLEN-1:0]   rs1_data;
  logic [`XLEN-1:0]   rs2_data;

  bru_issue_queue u_queue (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_disp_valid      (i_disp_valid),
    .o_disp_ready      (o_disp_ready),
    .i_disp_cmt_id     (i_disp_cmt_id),
    .i_disp_op         (i_disp_op),
    .i_disp_rs1        (i_disp_rs1),
    .i_disp_rs2        (i_disp_rs2),
    .i_disp_rs1_ready  (i_disp_rs1_ready),
    .i_disp_rs2_ready  (i_disp_rs2_ready),
    .i_disp_pred_taken (i_disp_pred_taken),
    .i_wb_valid        (i_wb_valid),
    .i_wb_preg         (i_wb_preg),
    .i_early_valid     (i_early_valid),
    .i_early_preg      (i_early_preg),
    .i_cancel_valid    (i_cancel_valid),
    .i_cancel_preg     (i_cancel_preg),
    .o_iss_valid       (iss_valid),
    .i_iss_ready       (iss_ready),
    .o_iss_op          (iss_op),
    .o_iss_cmt_id      (iss_cmt_id),
    .o_iss_rs1         (iss_rs1),
    .o_iss_rs2         (iss_rs2),
    .o_iss_pred_taken  (iss_pred_taken),
    .o_replay          (replay),
    .i_flush_valid     (flush_valid),
    .i_flush_cmt_id    (flush_cmt_id)
  );

  bru_regfile u_regfile (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_wb_valid (i_wb_valid),
    .i_wb_preg  (i_wb_preg),
    .i_wb_data  (i_wb_data),
    .i_rd_rs1   (rd_rs1),
    .i_rd_rs2   (rd_rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  bru_exec u_exec (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_iss_valid      (iss_valid),
    .o_iss_ready      (iss_ready),
    .i_iss_op         (iss_op),
    .i_iss_cmt_id     (iss_cmt_id),
    .i_iss_rs1        (iss_rs1),
    .i_iss_rs2        (iss_rs2),
    .i_iss_pred_taken (iss_pred_taken),
    .i_replay         (replay),
    .o_rd_rs1         (rd_rs1),
    .o_rd_rs2         (rd_rs2),
    .i_rs1_data       (rs1_data),
    .i_rs2_data       (rs2_data),
    .o_res_valid      (o_res_valid),
    .i_res_ready      (i_res_ready),
    .o_res_cmt_id     (o_res_cmt_id),
    .o_res_taken      (o_res_taken),
    .o_res_mispred    (o_res_mispred),
    .o_flush_valid    (flush_valid),
    .o_flush_cmt_id   (flush_cmt_id)
  );

endmodule

// ==== bru_exec.sv ====
`timescale 1ns/1ps
`include "bru_consts.svh"

module bru_exec
  import bru_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  logic               i_iss_valid,
  output logic               o_iss_ready,
  input  br_op_t             i_iss_op,
  input  logic [`AGE_W-1:0]  i_iss_cmt_id,
  input  logic [`PREG_W-1:0] i_iss_rs1,
  input  logic [`PREG_W-1:0] i_iss_rs2,
  input  logic               i_iss_pred_taken,
  input  logic               i_replay,
  output logic [`PREG_W-1:0] o_rd_rs1,
  output logic [`PREG_W-1:0] o_rd_rs2,
  input  logic [`XLEN-1:0]   i_rs1_data,
  input  logic [`XLEN-1:0]   i_rs2_data,
  output logic               o_res_valid,
  input  logic               i_res_ready,
  output logic [`AGE_W-1:0]  o_res_cmt_id,
  output logic               o_res_taken,
  output logic               o_res_mispred,
  output logic               o_flush_valid,
  output logic [`AGE_W-1:0]  o_flush_cmt_id
);

  logic               r_a_valid;
  br_op_t             r_a_op;
  logic [`AGE_W-1:0]  r_a_cmt_id;
  logic [`PREG_W-1:0] r_a_rs1;
  logic [`PREG_W-1:0] r_a_rs2;
  logic               r_a_pred;
  logic               r_res_fresh;  // First cycle of this result
  logic               w_res_accept;
  logic               w_a_kill;
  logic               w_a_go;
  logic               w_iss_fire;
  logic               w_eq;
  logic               w_lt;
  logic               w_taken;

  // ----------------------------------------
  // Stage A, operand read and compare
  // ----------------------------------------
  assign w_res_accept = !o_res_valid || i_res_ready;
  assign o_iss_ready  = !r_a_valid || w_res_accept;
  assign w_a_kill     = i_replay || (o_flush_valid && is_younger(r_a_cmt_id, o_res_cmt_id));
  assign w_a_go       = r_a_valid && !w_a_kill;
  assign w_iss_fire   = i_iss_valid && o_iss_ready &&
                        !(o_flush_valid && is_younger(i_iss_cmt_id, o_res_cmt_id));

  assign o_rd_rs1 = r_a_rs1;
  assign o_rd_rs2 = r_a_rs2;

  assign w_eq = (i_rs1_data == i_rs2_data);
  assign w_lt = (r_a_op == BLT || r_a_op == BGE) ? ($signed(i_rs1_data) < $signed(i_rs2_data))
                                                 : (i_rs1_data < i_rs2_data);

  always_comb begin
    case (r_a_op)
      BEQ:         w_taken = w_eq;
      BNE:         w_taken = !w_eq;
      BLT, BLTU:   w_taken = w_lt;
      BGE, BGEU:   w_taken = !w_lt;
      default:     w_taken = 1'b0;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_a_valid <= 1'b0;
    end else if (o_iss_ready) begin
      r_a_valid <= w_iss_fire;
    end else if (w_a_kill) begin
      r_a_valid <= 1'b0;  // Replayed or flushed while stalled
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_iss_ready && i_iss_valid) begin
      r_a_op     <= i_iss_op;
      r_a_cmt_id <= i_iss_cmt_id;
      r_a_rs1    <= i_iss_rs1;
      r_a_rs2    <= i_iss_rs2;
      r_a_pred   <= i_iss_pred_taken;
    end
  end

  // ----------------------------------------
  // Result register
  // ----------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_res_valid <= 1'b0;
      r_res_fresh <= 1'b0;
    end else if (w_res_accept) begin
      o_res_valid <= w_a_go;
      r_res_fresh <= w_a_go;
    end else begin
      r_res_fresh <= 1'b0;  // Held, flush already sent
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_res_accept && w_a_go) begin
      o_res_cmt_id  <= r_a_cmt_id;
      o_res_taken   <= w_taken;
      o_res_mispred <= w_taken ^ r_a_pred;
    end
  end

  assign o_flush_valid  = o_res_valid && o_res_mispred && r_res_fresh;
  assign o_flush_cmt_id = o_res_cmt_id;

endmodule

// ==== bru_regfile.sv ====
`timescale 1ns/1ps
`include "bru_consts.svh"

module bru_regfile (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  logic               i_wb_valid,
  input  logic [`PREG_W-1:0] i_wb_preg,
  input  logic [`XLEN-1:0]   i_wb_data,
  input  logic [`PREG_W-1:0] i_rd_rs1,
  input  logic [`PREG_W-1:0] i_rd_rs2,
  output logic [`XLEN-1:0]   o_rs1_data,
  output logic [`XLEN-1:0]   o_rs2_data
);

  localparam int NREGS = 1 << `PREG_W;

  logic [`XLEN-1:0] r_regs [NREGS];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < NREGS; i++) begin
        r_regs[i] <= '0;
      end
    end else if (i_wb_valid) begin
      r_regs[i_wb_preg] <= i_wb_data;
    end
  end

  // Same-cycle writeback bypass
  assign o_rs1_data = (i_wb_valid && (i_wb_preg == i_rd_rs1)) ? i_wb_data
                                                              : r_regs[i_rd_rs1];
  assign o_rs2_data = (i_wb_valid && (i_wb_preg == i_rd_rs2)) ? i_wb_data
                                                              : r_regs[i_rd_rs2];

endmodule

// ==== bru_issue_queue.sv ====
`timescale 1ns/1ps
`include "bru_consts.svh"

module bru_issue_queue
  import bru_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  logic               i_disp_valid,
  output logic               o_disp_ready,
  input  logic [`AGE_W-1:0]  i_disp_cmt_id,
  input  br_op_t             i_disp_op,
  input  logic [`PREG_W-1:0] i_disp_rs1,
  input  logic [`PREG_W-1:0] i_disp_rs2,
  input  logic               i_disp_rs1_ready,
  input  logic               i_disp_rs2_ready,
  input  logic               i_disp_pred_taken,
  input  logic               i_wb_valid,
  input  logic [`PREG_W-1:0] i_wb_preg,
  input  logic               i_early_valid,
  input  logic [`PREG_W-1:0] i_early_preg,
  input  logic               i_cancel_valid,
  input  logic [`PREG_W-1:0] i_cancel_preg,
  output logic               o_iss_valid,
  input  logic               i_iss_ready,
  output br_op_t             o_iss_op,
  output logic [`AGE_W-1:0]  o_iss_cmt_id,
  output logic [`PREG_W-1:0] o_iss_rs1,
  output logic [`PREG_W-1:0] o_iss_rs2,
  output logic               o_iss_pred_taken,
  output logic               o_replay,
  input  logic               i_flush_valid,
  input  logic [`AGE_W-1:0]  i_flush_cmt_id
);

  localparam int IDX_W = (`BRU_ENTRIES > 1) ? $clog2(`BRU_ENTRIES) : 1;

  logic [`BRU_ENTRIES-1:0] w_free;
  logic [`BRU_ENTRIES-1:0] w_ready;
  logic [`BRU_ENTRIES-1:0] w_put;
  logic [`BRU_ENTRIES-1:0] w_picked;
  logic [`BRU_ENTRIES-1:0] w_replay;
  logic [`BRU_ENTRIES-1:0] w_pred;
  logic [`AGE_W-1:0]       w_cmt_id [`BRU_ENTRIES];
  br_op_t                  w_op     [`BRU_ENTRIES];
  logic [`PREG_W-1:0]      w_rs1    [`BRU_ENTRIES];
  logic [`PREG_W-1:0]      w_rs2    [`BRU_ENTRIES];
  logic [IDX_W-1:0]        w_free_idx;
  logic [IDX_W-1:0]        w_pick_idx;

  // Lowest free slot
  always_comb begin
    w_free_idx = '0;
    for (int i = `BRU_ENTRIES - 1; i >= 0; i--) begin
      if (w_free[i]) w_free_idx = IDX_W'(i);
    end
  end

  // Oldest ready entry by program-order id
  always_comb begin
    logic found;
    found      = 1'b0;
    w_pick_idx = '0;
    for (int i = 0; i < `BRU_ENTRIES; i++) begin
      if (w_ready[i] && (!found || is_younger(w_cmt_id[w_pick_idx], w_cmt_id[i]))) begin
        w_pick_idx = IDX_W'(i);
        found      = 1'b1;
      end
    end
  end

  for (genvar g = 0; g < `BRU_ENTRIES; g++) begin : g_entry
    assign w_put[g]    = i_disp_valid & o_disp_ready & (w_free_idx == IDX_W'(g));
    assign w_picked[g] = o_iss_valid & i_iss_ready & (w_pick_idx == IDX_W'(g));

    bru_issue_entry u_entry (
      .i_clk            (i_clk),
      .i_reset_n        (i_reset_n),
      .i_put            (w_put[g]),
      .i_put_cmt_id     (i_disp_cmt_id),
      .i_put_op         (i_disp_op),
      .i_put_rs1        (i_disp_rs1),
      .i_put_rs2        (i_disp_rs2),
      .i_put_rs1_ready  (i_disp_rs1_ready),
      .i_put_rs2_ready  (i_disp_rs2_ready),
      .i_put_pred_taken (i_disp_pred_taken),
      .i_wb_valid       (i_wb_valid),
      .i_wb_preg        (i_wb_preg),
      .i_early_valid    (i_early_valid),
      .i_early_preg     (i_early_preg),
      .i_cancel_valid   (i_cancel_valid),
      .i_cancel_preg    (i_cancel_preg),
      .i_picked         (w_picked[g]),
      .i_flush_valid    (i_flush_valid),
      .i_flush_cmt_id   (i_flush_cmt_id),
      .o_free           (w_free[g]),
      .o_ready          (w_ready[g]),
      .o_cmt_id         (w_cmt_id[g]),
      .o_op             (w_op[g]),
      .o_rs1            (w_rs1[g]),
      .o_rs2            (w_rs2[g]),
      .o_pred_taken     (w_pred[g]),
      .o_replay         (w_replay[g])
    );
  end

  assign o_disp_ready     = |w_free;
  assign o_iss_valid      = |w_ready;
  assign o_iss_op         = w_op[w_pick_idx];
  assign o_iss_cmt_id     = w_cmt_id[w_pick_idx];
  assign o_iss_rs1        = w_rs1[w_pick_idx];
  assign o_iss_rs2        = w_rs2[w_pick_idx];
  assign o_iss_pred_taken = w_pred[w_pick_idx];
  assign o_replay         = |w_replay;  // At most one ISSUED entry

endmodule

// ==== bru_issue_entry.sv ====
`timescale 1ns/1ps
`include "bru_consts.svh"

module bru_issue_entry
  import bru_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  logic               i_put,
  input  logic [`AGE_W-1:0]  i_put_cmt_id,
  input  br_op_t             i_put_op,
  input  logic [`PREG_W-1:0] i_put_rs1,
  input  logic [`PREG_W-1:0] i_put_rs2,
  input  logic               i_put_rs1_ready,
  input  logic               i_put_rs2_ready,
  input  logic               i_put_pred_taken,
  input  logic               i_wb_valid,
  input  logic [`PREG_W-1:0] i_wb_preg,
  input  logic               i_early_valid,
  input  logic [`PREG_W-1:0] i_early_preg,
  input  logic               i_cancel_valid,
  input  logic [`PREG_W-1:0] i_cancel_preg,
  input  logic               i_picked,
  input  logic               i_flush_valid,
  input  logic [`AGE_W-1:0]  i_flush_cmt_id,
  output logic               o_free,
  output logic               o_ready,
  output logic [`AGE_W-1:0]  o_cmt_id,
  output br_op_t             o_op,
  output logic [`PREG_W-1:0] o_rs1,
  output logic [`PREG_W-1:0] o_rs2,
  output logic               o_pred_taken,
  output logic               o_replay
);

  sched_state_t                 r_state;
  logic [`AGE_W-1:0]            r_cmt_id;
  br_op_t                       r_op;
  logic [1:0][`PREG_W-1:0]      r_rs;
  logic [1:0]                   r_rdy;   // Final ready per source
  logic [1:0]                   r_spec;  // Early wakeup seen last cycle
  logic                         r_pred_taken;

  logic [1:0][`PREG_W-1:0]      w_rs;
  logic [1:0]                   w_rdy_base;
  logic [1:0]                   w_wb_hit;
  logic [1:0]                   w_early_hit;
  logic [1:0]                   w_cancel_hit;
  logic                         w_flush_hit;

  // ----------------------------------------
  // Wakeup compare, against the incoming op on put
  // ----------------------------------------
  always_comb begin
    w_rs[0]    = i_put ? i_put_rs1 : r_rs[0];
    w_rs[1]    = i_put ? i_put_rs2 : r_rs[1];
    w_rdy_base = i_put ? {i_put_rs2_ready, i_put_rs1_ready} : r_rdy;
    for (int k = 0; k < 2; k++) begin
      w_wb_hit[k]     = i_wb_valid & (i_wb_preg == w_rs[k]);
      w_early_hit[k]  = i_early_valid & (i_early_preg == w_rs[k]);
      w_cancel_hit[k] = i_cancel_valid & (i_cancel_preg == r_rs[k]) & r_spec[k];
    end
  end

  assign w_flush_hit = i_flush_valid &
                       is_younger(i_put ? i_put_cmt_id : r_cmt_id, i_flush_cmt_id);

  // Early hit counts as ready so the pick lines up with the promised writeback
  assign o_ready  = (r_state == WAIT) & (&(r_rdy | w_wb_hit | w_early_hit));
  assign o_replay = (r_state == ISSUED) & (|w_cancel_hit);
  assign o_free   = (r_state == FREE);

  // ----------------------------------------
  // State and ready bits
  // ----------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= FREE;
      r_rdy   <= '0;
      r_spec  <= '0;
    end else begin
      r_rdy  <= w_rdy_base | w_wb_hit;
      r_spec <= w_early_hit & ~(w_rdy_base | w_wb_hit);  // Only lives one cycle
      case (r_state)
        FREE: begin
          if (i_put && !w_flush_hit) begin
            r_state <= WAIT;
          end
        end
        WAIT: begin
          if (w_flush_hit) begin
            r_state <= FREE;
          end else if (i_picked) begin
            r_state <= ISSUED;
          end
        end
        ISSUED: begin
          if (!w_flush_hit && o_replay) begin
            r_state <= WAIT;  // Speculative source withdrawn
          end else begin
            r_state <= FREE;
          end
        end
        default: r_state <= FREE;
      endcase
    end
  end

  // Payload, loaded on put
  always_ff @(posedge i_clk) begin
    if (i_put) begin
      r_cmt_id     <= i_put_cmt_id;
      r_op         <= i_put_op;
      r_rs         <= w_rs;
      r_pred_taken <= i_put_pred_taken;
    end
  end

  assign o_cmt_id     = r_cmt_id;
  assign o_op         = r_op;
  assign o_rs1        = r_rs[0];
  assign o_rs2        = r_rs[1];
  assign o_pred_taken = r_pred_taken;

endmodule

// ==== bru_pkg.sv ====
`include "bru_consts.svh"

package bru_pkg;

  // Conditional branch kinds
  typedef enum logic [2:0] {
    BEQ  = 3'd0,
    BNE  = 3'd1,
    BLT  = 3'd2,
    BGE  = 3'd3,
    BLTU = 3'd4,
    BGEU = 3'd5
  } br_op_t;

  // Scheduler entry lifecycle
  typedef enum logic [1:0] {
    FREE   = 2'd0,
    WAIT   = 2'd1,
    ISSUED = 2'd2
  } sched_state_t;

  // True when id a is ahead of id b within the wrap window
  function automatic logic is_younger(input logic [`AGE_W-1:0] a,
                                      input logic [`AGE_W-1:0] b);
    logic [`AGE_W-1:0] diff;
    diff = a - b;
    return (diff != '0) && !diff[`AGE_W-1];
  endfunction

endpackage

// ==== bru_consts.svh ====
`ifndef BRU_CONSTS_SVH
`define BRU_CONSTS_SVH

// Scheduler sizing
`define BRU_ENTRIES 4

// Physical tag width, 32 registers
`define PREG_W 5

// Operand width
`define XLEN 32

// Program-order id, top bit is the wrap bit
`define AGE_W 4

`endif
